/* sim.f */
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tests/tb_mem_slave.sv
tests/dcache_tb.sv

/* tests/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

  localparam int unsigned SEED       = 32'h953f_7cda;
  localparam int          INDEX_W    = 6;
  localparam int          LINES      = 1 << INDEX_W;
  localparam int          TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int          CPU_WAIT   = 500;
  localparam int          FENCE_WAIT = 8000;

  logic              clk = 1'b0;
  logic              rst;
  logic              cpu_valid;
  cpu_req_t          cpu_req;
  logic [XLEN-1:0]   cpu_rdata;
  logic              cpu_ready;
  logic              fencei_valid;
  logic              fencei_ready;
  logic [ADDR_W-1:0] mem_rd_addr;
  logic              mem_rd_valid;
  logic              mem_rd_ready;
  logic [XLEN-1:0]   mem_rd_data;
  logic [ADDR_W-1:0] mem_wr_addr;
  logic              mem_wr_valid;
  logic [XLEN-1:0]   mem_wr_data;
  logic              mem_wr_ready;
  int                rd_beats;
  int                wr_beats;
  logic [ADDR_W-1:0] last_rd_addr;
  logic [ADDR_W-1:0] last_wr_addr;

  integer            seed;
  int                checks;
  int                errors;
  int                err_mark;
  bit                hung;

  logic [XLEN-1:0]   gold [logic [28:0]];  // flat memory, word addressed
  logic [TAG_W-1:0]  sh_tag [LINES];
  logic [LINES-1:0]  sh_valid;
  logic [LINES-1:0]  sh_dirty;
  logic [2:0]        mon_beat;
  logic              wr_stall;
  logic [ADDR_W-1:0] stall_addr;
  logic [XLEN-1:0]   stall_data;

  always #5 clk = ~clk;

  dcache_top #(
    .INDEX_W(INDEX_W)
  ) u_dut (
    .clk           (clk),
    .rst           (rst),
    .cpu_valid_i   (cpu_valid),
    .cpu_req_i     (cpu_req),
    .cpu_rdata_o   (cpu_rdata),
    .cpu_ready_o   (cpu_ready),
    .fencei_valid_i(fencei_valid),
    .fencei_ready_o(fencei_ready),
    .mem_rd_addr_o (mem_rd_addr),
    .mem_rd_valid_o(mem_rd_valid),
    .mem_rd_ready_i(mem_rd_ready),
    .mem_rd_data_i (mem_rd_data),
    .mem_wr_addr_o (mem_wr_addr),
    .mem_wr_valid_o(mem_wr_valid),
    .mem_wr_data_o (mem_wr_data),
    .mem_wr_ready_i(mem_wr_ready)
  );

  tb_mem_slave #(
    .SEED(SEED ^ 32'h0000_5a5a)
  ) u_mem (
    .clk           (clk),
    .rst           (rst),
    .rd_addr_i     (mem_rd_addr),
    .rd_valid_i    (mem_rd_valid),
    .rd_ready_o    (mem_rd_ready),
    .rd_data_o     (mem_rd_data),
    .wr_addr_i     (mem_wr_addr),
    .wr_valid_i    (mem_wr_valid),
    .wr_data_i     (mem_wr_data),
    .wr_ready_o    (mem_wr_ready),
    .rd_beats_o    (rd_beats),
    .wr_beats_o    (wr_beats),
    .last_rd_addr_o(last_rd_addr),
    .last_wr_addr_o(last_wr_addr)
  );

  task automatic expect_true(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("[FAIL] %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  function automatic logic [XLEN-1:0] gold_word(input logic [28:0] waddr);
    if (gold.exists(waddr)) begin
      return gold[waddr];
    end
    return u_mem.fill_word(waddr);  // untouched words keep the initial pattern
  endfunction

  task automatic gold_write(input cpu_req_t req);
    logic [XLEN-1:0] w;
    w = gold_word(req.addr[31:3]);
    for (int b = 0; b < MASK_W; b++) begin
      if (req.mask[b]) begin
        w[8*b +: 8] = req.wdata[8*b +: 8];
      end
    end
    gold[req.addr[31:3]] = w;
  endtask

  function automatic cpu_req_t random_req(input bit allow_write);
    cpu_req_t r;
    r.addr  = {20'h4_0a00 + 20'($unsigned($random(seed)) % 4),  // four tags
               6'($unsigned($random(seed)) % 64),
               3'($unsigned($random(seed)) % 8), 3'b000};
    r.wdata = {$random(seed), $random(seed)};
    r.mask  = 8'($random(seed));
    r.write = allow_write && 1'($random(seed));
    return r;
  endfunction

  // write-back data and stall stability, sampled mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      mon_beat = '0;
      wr_stall = 1'b0;
    end else begin
      if (wr_stall) begin
        expect_true(mem_wr_valid && mem_wr_addr == stall_addr && mem_wr_data == stall_data,
                    "write burst changed while stalled");
      end
      if (mem_wr_valid && mem_wr_ready) begin
        expect_true(mem_wr_data == gold_word(mem_wr_addr[31:3] + 29'(mon_beat)),
                    $sformatf("write-back %h beat %0d data %h", mem_wr_addr, mon_beat,
                              mem_wr_data));
        mon_beat = mon_beat + 1'b1;
      end
      wr_stall   = mem_wr_valid && !mem_wr_ready;
      stall_addr = mem_wr_addr;
      stall_data = mem_wr_data;
    end
  end

  task automatic check_quiet(input string when);
    expect_true(!cpu_ready && !fencei_ready && !mem_rd_valid && !mem_wr_valid,
                {"outputs active ", when});
  endtask

  task automatic run_request(input cpu_req_t req);
    int                idx;
    int                cycles;
    int                rd0;
    int                wr0;
    bit                resident;
    bit                evict;
    bit                mem_seen;
    logic [ADDR_W-1:0] victim;
    idx      = req.addr[OFFSET_W +: INDEX_W];
    resident = sh_valid[idx] && sh_tag[idx] == req.addr[ADDR_W-1 -: TAG_W];
    evict    = !resident && sh_valid[idx] && sh_dirty[idx];
    victim   = {sh_tag[idx], req.addr[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}};
    rd0      = rd_beats;
    wr0      = wr_beats;
    mem_seen = 1'b0;
    @(posedge clk);
    cpu_valid <= 1'b1;
    cpu_req   <= req;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      mem_seen = mem_seen || mem_rd_valid || mem_wr_valid;
    end while (!cpu_ready && cycles < CPU_WAIT);
    if (!cpu_ready) begin
      hung = 1'b1;
      $display("timed out after %0d cycles waiting for cpu_ready_o, address %h",
               CPU_WAIT, req.addr);
      return;
    end
    if (!req.write) begin
      expect_true(cpu_rdata == gold_word(req.addr[31:3]),
                  $sformatf("read %h returned %h, expected %h", req.addr, cpu_rdata,
                            gold_word(req.addr[31:3])));
    end
    if (resident) begin
      expect_true(cycles == 2 && !mem_seen && rd_beats == rd0 && wr_beats == wr0,
                  $sformatf("hit at %h took %0d cycles or touched memory", req.addr, cycles));
    end else begin
      expect_true(rd_beats - rd0 == 8 && last_rd_addr == {req.addr[31:6], 6'b0},
                  $sformatf("refill for %h: %0d beats at %h", req.addr, rd_beats - rd0,
                            last_rd_addr));
      expect_true(wr_beats - wr0 == (evict ? 8 : 0) && (!evict || last_wr_addr == victim),
                  $sformatf("eviction for %h: %0d beats at %h", req.addr, wr_beats - wr0,
                            last_wr_addr));
      sh_valid[idx] = 1'b1;
      sh_tag[idx]   = req.addr[ADDR_W-1 -: TAG_W];
      sh_dirty[idx] = 1'b0;
    end
    if (req.write) begin
      gold_write(req);
      sh_dirty[idx] = 1'b1;
    end
  endtask

  task automatic run_fence();
    int cycles;
    int rd0;
    int wr0;
    int dirty;
    dirty = $countones(sh_dirty & sh_valid);
    rd0   = rd_beats;
    wr0   = wr_beats;
    @(posedge clk);
    cpu_valid    <= 1'b0;
    fencei_valid <= 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!fencei_ready && cycles < FENCE_WAIT);
    if (!fencei_ready) begin
      hung = 1'b1;
      $display("timed out after %0d cycles waiting for fencei_ready_o", FENCE_WAIT);
      return;
    end
    expect_true(wr_beats - wr0 == 8 * dirty && rd_beats == rd0,
                $sformatf("fence.i wrote %0d beats for %0d dirty lines", wr_beats - wr0, dirty));
    foreach (gold[w]) begin
      expect_true(u_mem.word_at(w) == gold[w],
                  $sformatf("memory word %h is %h after fence.i", {w, 3'b000}, u_mem.word_at(w)));
    end
    sh_dirty = '0;
    @(posedge clk);
    fencei_valid <= 1'b0;
  endtask

  task automatic report_test(input string name);
    $display("test %-14s %s, %0d errors", name,
             hung ? "stopped" : (errors == err_mark ? "ok" : "failed"), errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    seed         = SEED;
    checks       = 0;
    errors       = 0;
    err_mark     = 0;
    hung         = 1'b0;
    sh_valid     = '0;
    sh_dirty     = '0;
    rst          = 1'b1;
    cpu_valid    = 1'b0;
    cpu_req      = '0;
    fencei_valid = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_quiet("during reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_quiet("in the first cycle after reset");
    report_test("reset");
    for (int i = 0; i < 400 && !hung; i++) begin
      run_request(random_req(1'b1));
    end
    report_test("random");
    if (!hung) begin
      run_fence();
    end
    report_test("fence.i");
    if (!hung) begin
      run_fence();  // nothing left dirty
    end
    report_test("fence.i again");
    for (int i = 0; i < 100 && !hung; i++) begin
      run_request(random_req(1'b0));
    end
    report_test("after flush");
    $display("checks %0d, errors %0d", checks, errors);
    if (hung || errors != 0) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  end

endmodule

/* tests/tb_mem_slave.sv */
`timescale 1ns/1ps

module tb_mem_slave import dcache_pkg::*; #(
  parameter int unsigned SEED = 1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] rd_addr_i,
  input  logic              rd_valid_i,
  output logic              rd_ready_o,
  output logic [XLEN-1:0]   rd_data_o,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic              wr_valid_i,
  input  logic [XLEN-1:0]   wr_data_i,
  output logic              wr_ready_o,
  output int                rd_beats_o,
  output int                wr_beats_o,
  output logic [ADDR_W-1:0] last_rd_addr_o,
  output logic [ADDR_W-1:0] last_wr_addr_o
);

  logic [XLEN-1:0] store [logic [28:0]];  // keyed by word address
  logic [2:0]      rd_beat_q;
  logic [2:0]      wr_beat_q;
  logic [2:0]      rd_next;
  integer          seed;

  function automatic logic [XLEN-1:0] fill_word(input logic [28:0] waddr);
    return {waddr, 3'b101, 32'h6a09_e667 ^ {3'b000, waddr}};
  endfunction

  function automatic logic [XLEN-1:0] word_at(input logic [28:0] waddr);
    if (store.exists(waddr)) begin
      return store[waddr];
    end
    return fill_word(waddr);
  endfunction

  initial begin
    seed       = SEED;
    rd_ready_o = 1'b0;
    wr_ready_o = 1'b0;
    rd_data_o  = '0;
  end

  // ready only follows a valid already seen, so the address is settled
  always @(posedge clk) begin
    if (rst) begin
      rd_ready_o <= 1'b0;
      wr_ready_o <= 1'b0;
      rd_beat_q  <= '0;
      wr_beat_q  <= '0;
      rd_beats_o <= 0;
      wr_beats_o <= 0;
    end else begin
      rd_next = rd_beat_q + 3'(rd_valid_i && rd_ready_o);
      if (wr_valid_i && wr_ready_o) begin
        store[wr_addr_i[31:3] + 29'(wr_beat_q)] = wr_data_i;
        wr_beat_q  <= wr_beat_q + 1'b1;
        wr_beats_o <= wr_beats_o + 1;
        if (wr_beat_q == 3'd7) begin
          last_wr_addr_o <= wr_addr_i;
        end
      end
      if (rd_valid_i && rd_ready_o) begin
        rd_beat_q  <= rd_next;
        rd_beats_o <= rd_beats_o + 1;
        if (rd_beat_q == 3'd7) begin
          last_rd_addr_o <= rd_addr_i;
        end
      end
      rd_data_o  <= word_at(rd_addr_i[31:3] + 29'(rd_next));  // beat k is word k
      rd_ready_o <= rd_valid_i && ($unsigned($random(seed)) % 4 != 0);
      wr_ready_o <= wr_valid_i && ($unsigned($random(seed)) % 4 != 0);
    end
  end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
  parameter  int INDEX_W = 6,
  localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cpu_valid_i,
  input  cpu_req_t          cpu_req_i,
  output logic [XLEN-1:0]   cpu_rdata_o,
  output logic              cpu_ready_o,
  input  logic              fencei_valid_i,
  output logic              fencei_ready_o,
  output logic [ADDR_W-1:0] mem_rd_addr_o,
  output logic              mem_rd_valid_o,
  input  logic              mem_rd_ready_i,
  input  logic [XLEN-1:0]   mem_rd_data_i,
  output logic [ADDR_W-1:0] mem_wr_addr_o,
  output logic              mem_wr_valid_o,
  output logic [XLEN-1:0]   mem_wr_data_o,
  input  logic              mem_wr_ready_i
);

  logic [INDEX_W-1:0]    tag_index;
  logic [TAG_W-1:0]      tag_wdata;
  logic                  tag_fill;
  logic                  tag_set_dirty;
  logic                  tag_flush;
  logic                  tag_hit;
  logic                  tag_dirty;
  logic [TAG_W-1:0]      tag_rdata;

  logic [INDEX_W-1:0]    data_index;
  logic [WORD_SEL_W-1:0] data_word;
  logic [XLEN-1:0]       data_wdata;
  logic [MASK_W-1:0]     data_wmask;
  logic                  data_we;
  logic [XLEN-1:0]       data_rdata;

  assign cpu_rdata_o = data_rdata;  // addressed word during the ready cycle

  dcache_ctrl #(
    .INDEX_W(INDEX_W)
  ) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .cpu_valid_i    (cpu_valid_i),
    .cpu_req_i      (cpu_req_i),
    .cpu_ready_o    (cpu_ready_o),
    .fencei_valid_i (fencei_valid_i),
    .fencei_ready_o (fencei_ready_o),
    .mem_rd_addr_o  (mem_rd_addr_o),
    .mem_rd_valid_o (mem_rd_valid_o),
    .mem_rd_ready_i (mem_rd_ready_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .mem_wr_addr_o  (mem_wr_addr_o),
    .mem_wr_valid_o (mem_wr_valid_o),
    .mem_wr_data_o  (mem_wr_data_o),
    .mem_wr_ready_i (mem_wr_ready_i),
    .tag_index_o    (tag_index),
    .tag_wdata_o    (tag_wdata),
    .tag_fill_o     (tag_fill),
    .tag_set_dirty_o(tag_set_dirty),
    .tag_flush_o    (tag_flush),
    .tag_hit_i      (tag_hit),
    .tag_dirty_i    (tag_dirty),
    .tag_rdata_i    (tag_rdata),
    .data_index_o   (data_index),
    .data_word_o    (data_word),
    .data_wdata_o   (data_wdata),
    .data_wmask_o   (data_wmask),
    .data_we_o      (data_we),
    .data_rdata_i   (data_rdata)
  );

  dcache_tag_array #(
    .INDEX_W(INDEX_W)
  ) u_tag_array (
    .clk        (clk),
    .rst        (rst),
    .index_i    (tag_index),
    .tag_i      (tag_wdata),
    .fill_i     (tag_fill),
    .set_dirty_i(tag_set_dirty),
    .flush_i    (tag_flush),
    .hit_o      (tag_hit),
    .dirty_o    (tag_dirty),
    .tag_o      (tag_rdata)
  );

  dcache_data_array #(
    .INDEX_W(INDEX_W)
  ) u_data_array (
    .clk    (clk),
    .index_i(data_index),
    .word_i (data_word),
    .wdata_i(data_wdata),
    .wmask_i(data_wmask),
    .we_i   (data_we),
    .rdata_o(data_rdata)
  );

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
  parameter  int INDEX_W = 6,
  localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W
) (
  input  logic                  clk,
  input  logic                  rst,
  // cpu side
  input  logic                  cpu_valid_i,
  input  cpu_req_t              cpu_req_i,
  output logic                  cpu_ready_o,
  // fence.i
  input  logic                  fencei_valid_i,
  output logic                  fencei_ready_o,
  // memory read channel
  output logic [ADDR_W-1:0]     mem_rd_addr_o,
  output logic                  mem_rd_valid_o,
  input  logic                  mem_rd_ready_i,
  input  logic [XLEN-1:0]       mem_rd_data_i,
  // memory write channel
  output logic [ADDR_W-1:0]     mem_wr_addr_o,
  output logic                  mem_wr_valid_o,
  output logic [XLEN-1:0]       mem_wr_data_o,
  input  logic                  mem_wr_ready_i,
  // tag array
  output logic [INDEX_W-1:0]    tag_index_o,
  output logic [TAG_W-1:0]      tag_wdata_o,
  output logic                  tag_fill_o,
  output logic                  tag_set_dirty_o,
  output logic                  tag_flush_o,
  input  logic                  tag_hit_i,
  input  logic                  tag_dirty_i,
  input  logic [TAG_W-1:0]      tag_rdata_i,
  // data array
  output logic [INDEX_W-1:0]    data_index_o,
  output logic [WORD_SEL_W-1:0] data_word_o,
  output logic [XLEN-1:0]       data_wdata_o,
  output logic [MASK_W-1:0]     data_wmask_o,
  output logic                  data_we_o,
  input  logic [XLEN-1:0]       data_rdata_i
);

  typedef enum logic [2:0] {
    ST_RST,
    ST_IDLE,
    ST_WB,          // victim write-back before refill
    ST_REFILL,
    ST_FENCE_STEP,
    ST_FENCE_WB
  } state_t;

  state_t                state_q;
  logic [WORD_SEL_W-1:0] beat_q;
  logic [INDEX_W:0]      fence_idx_q;   // msb set once all lines visited
  logic                  cpu_ready_q;
  logic                  fencei_ready_q;
  logic                  rd_valid_q;
  logic                  wr_valid_q;
  logic [ADDR_W-1:0]     rd_addr_q;
  logic [ADDR_W-1:0]     wr_addr_q;

  logic [TAG_W-1:0]      req_tag;
  logic [INDEX_W-1:0]    req_index;
  logic [WORD_SEL_W-1:0] req_word;
  logic [INDEX_W-1:0]    line_index;
  logic                  lookup;
  logic                  fence_go;
  logic                  write_hit;
  logic                  rd_beat;
  logic                  wr_beat;
  logic                  last_beat;
  logic                  refill_we;
  logic                  fence_end;
  logic                  in_fence;
  logic                  in_burst;

  assign req_tag   = cpu_req_i.addr[ADDR_W-1 -: TAG_W];
  assign req_index = cpu_req_i.addr[OFFSET_W +: INDEX_W];
  assign req_word  = cpu_req_i.addr[BYTE_SEL_W +: WORD_SEL_W];

  // no lookup in our own ready cycle
  assign lookup    = (state_q == ST_IDLE) && cpu_valid_i && !cpu_ready_q;
  assign fence_go  = (state_q == ST_IDLE) && !cpu_valid_i && fencei_valid_i && !fencei_ready_q;
  assign write_hit = lookup && tag_hit_i && cpu_req_i.write;

  assign rd_beat   = rd_valid_q && mem_rd_ready_i;
  assign wr_beat   = wr_valid_q && mem_wr_ready_i;
  assign last_beat = (beat_q == WORD_SEL_W'(LINE_WORDS - 1));
  assign refill_we = (state_q == ST_REFILL) && rd_beat;
  assign fence_end = (state_q == ST_FENCE_STEP) && fence_idx_q[INDEX_W];

  assign in_fence  = state_q inside {ST_FENCE_STEP, ST_FENCE_WB};
  assign in_burst  = state_q inside {ST_WB, ST_REFILL, ST_FENCE_WB};

  assign line_index = in_fence ? fence_idx_q[INDEX_W-1:0] : req_index;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= ST_RST;
      beat_q         <= '0;
      fence_idx_q    <= '0;
      cpu_ready_q    <= 1'b0;
      fencei_ready_q <= 1'b0;
      rd_valid_q     <= 1'b0;
      wr_valid_q     <= 1'b0;
    end else begin
      cpu_ready_q    <= 1'b0;  // both readies are single-cycle pulses
      fencei_ready_q <= 1'b0;
      case (state_q)
        ST_RST: begin
          state_q <= ST_IDLE;
        end
        ST_IDLE: begin
          beat_q <= '0;
          if (lookup) begin
            if (tag_hit_i) begin
              cpu_ready_q <= 1'b1;
            end else if (tag_dirty_i) begin
              wr_valid_q <= 1'b1;
              state_q    <= ST_WB;
            end else begin
              rd_valid_q <= 1'b1;
              state_q    <= ST_REFILL;
            end
          end else if (fence_go) begin
            fence_idx_q <= '0;
            state_q     <= ST_FENCE_STEP;
          end
        end
        ST_WB: begin
          if (wr_beat) begin
            beat_q <= beat_q + 1'b1;  // wraps to 0 for the refill
            if (last_beat) begin
              wr_valid_q <= 1'b0;
              rd_valid_q <= 1'b1;
              state_q    <= ST_REFILL;
            end
          end
        end
        ST_REFILL: begin
          if (rd_beat) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              rd_valid_q <= 1'b0;
              state_q    <= ST_IDLE;  // lookup again, now a hit
            end
          end
        end
        ST_FENCE_STEP: begin
          if (fence_end) begin
            fencei_ready_q <= 1'b1;
            state_q        <= ST_IDLE;
          end else if (tag_dirty_i) begin
            wr_valid_q <= 1'b1;
            beat_q     <= '0;
            state_q    <= ST_FENCE_WB;
          end else begin
            fence_idx_q <= fence_idx_q + 1'b1;
          end
        end
        ST_FENCE_WB: begin
          if (wr_beat) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              wr_valid_q  <= 1'b0;
              fence_idx_q <= fence_idx_q + 1'b1;
              state_q     <= ST_FENCE_STEP;
            end
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // burst addresses, line aligned
  always_ff @(posedge clk) begin
    if (lookup && !tag_hit_i) begin
      rd_addr_q <= {req_tag, req_index, {OFFSET_W{1'b0}}};
      wr_addr_q <= {tag_rdata_i, req_index, {OFFSET_W{1'b0}}};  // victim line
    end else if ((state_q == ST_FENCE_STEP) && !fence_end && tag_dirty_i) begin
      wr_addr_q <= {tag_rdata_i, fence_idx_q[INDEX_W-1:0], {OFFSET_W{1'b0}}};
    end
  end

  assign cpu_ready_o    = cpu_ready_q;
  assign fencei_ready_o = fencei_ready_q;
  assign mem_rd_addr_o  = rd_addr_q;
  assign mem_rd_valid_o = rd_valid_q;
  assign mem_wr_addr_o  = wr_addr_q;
  assign mem_wr_valid_o = wr_valid_q;
  assign mem_wr_data_o  = data_rdata_i;  // word selected by beat_q

  assign tag_index_o     = line_index;
  assign tag_wdata_o     = req_tag;
  assign tag_fill_o      = refill_we && last_beat;
  assign tag_set_dirty_o = write_hit;
  assign tag_flush_o     = fence_end;

  assign data_index_o = line_index;
  assign data_word_o  = in_burst ? beat_q : req_word;
  assign data_wdata_o = refill_we ? mem_rd_data_i : cpu_req_i.wdata;
  assign data_wmask_o = refill_we ? {MASK_W{1'b1}} : cpu_req_i.mask;
  assign data_we_o    = write_hit || refill_we;

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(mem_rd_valid_o && mem_wr_valid_o));

  // data comes from the array, so the held cpu request must keep the index steady
  a_wr_stable: assert property (@(posedge clk) disable iff (rst)
    mem_wr_valid_o && !mem_wr_ready_i |=>
      mem_wr_valid_o && $stable(mem_wr_addr_o) && $stable(mem_wr_data_o));

  a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
    cpu_ready_o |=> !cpu_ready_o);

endmodule

/* src/dcache_data_array.sv */
`timescale 1ns/1ps

module dcache_data_array import dcache_pkg::*; #(
  parameter int INDEX_W = 6
) (
  input  logic                  clk,
  input  logic [INDEX_W-1:0]    index_i,
  input  logic [WORD_SEL_W-1:0] word_i,
  input  logic [XLEN-1:0]       wdata_i,
  input  logic [MASK_W-1:0]     wmask_i,
  input  logic                  we_i,
  output logic [XLEN-1:0]       rdata_o
);

  localparam int LINES = 1 << INDEX_W;
  localparam int DEPTH = LINES * LINE_WORDS;

  logic [XLEN-1:0] mem_q [DEPTH];
  logic [INDEX_W+WORD_SEL_W-1:0] addr;

  assign addr    = {index_i, word_i};  // line-major word address
  assign rdata_o = mem_q[addr];        // async read

  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < MASK_W; b++) begin
        if (wmask_i[b]) begin
          mem_q[addr][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

/* src/dcache_tag_array.sv */
`timescale 1ns/1ps

module dcache_tag_array import dcache_pkg::*; #(
  parameter  int INDEX_W = 6,
  localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [INDEX_W-1:0] index_i,
  input  logic [TAG_W-1:0]   tag_i,
  input  logic               fill_i,
  input  logic               set_dirty_i,
  input  logic               flush_i,
  output logic               hit_o,
  output logic               dirty_o,
  output logic [TAG_W-1:0]   tag_o
);

  localparam int LINES = 1 << INDEX_W;

  logic [LINES-1:0] valid_q;
  logic [LINES-1:0] dirty_q;
  logic [TAG_W-1:0] tag_q [LINES];

  assign tag_o   = tag_q[index_i];
  assign hit_o   = valid_q[index_i] && (tag_q[index_i] == tag_i);
  assign dirty_o = valid_q[index_i] && dirty_q[index_i];  // only a valid line can be dirty

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (flush_i) begin
        dirty_q <= '0;  // valid bits survive the flush
      end
      if (fill_i) begin
        valid_q[index_i] <= 1'b1;
        dirty_q[index_i] <= 1'b0;  // freshly refilled
      end
      if (set_dirty_i) begin
        dirty_q[index_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_i) begin
      tag_q[index_i] <= tag_i;
    end
  end

  // a line is either being refilled or written by a store hit, never both
  a_fill_vs_dirty: assert property (@(posedge clk) disable iff (rst)
    !(fill_i && set_dirty_i));

endmodule

/* src/dcache_pkg.sv */
package dcache_pkg;

  // address layout: tag | index | offset
  localparam int ADDR_W     = 32;
  localparam int XLEN       = 64;   // cpu data word
  localparam int OFFSET_W   = 6;    // 64-byte line

  // offset splits into word select and byte select
  localparam int WORD_SEL_W = 3;
  localparam int BYTE_SEL_W = 3;

  localparam int LINE_WORDS = 8;    // also beats per burst
  localparam int MASK_W     = 8;    // one enable per byte of a word

  // one cpu load/store request
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
    logic [MASK_W-1:0] mask;   // byte enables, writes only
    logic              write;  // 1 = store, 0 = load
  } cpu_req_t;

endpackage
